//--- ln_pkg.sv
// shared widths, latencies and types for the layer-norm pre-processing stage
// values are Q5.10 fixed point, one vector carries LANES lanes
`default_nettype none

package ln_pkg;

    // ====================
    // sizes
    // ====================
    localparam int LANES      = 16;
    // log2 of LANES, divides by the lane count
    localparam int LANE_SHIFT = 4;
    localparam int Q_W        = 16;
    localparam int FRAC_BITS  = 10;
    // square keeps bits 31..10 of a 32-bit product
    localparam int SQ_W       = 2 * Q_W - FRAC_BITS;

    // ====================
    // pipeline latencies
    // ====================
    localparam int TREE_LAT = LANE_SHIFT;
    // tree plus the difference register
    localparam int MEAN_LAT = TREE_LAT + 1;
    // square register plus tree
    localparam int VAR_LAT  = TREE_LAT + 1;

    // ====================
    // types
    // ====================
    typedef logic signed [Q_W-1:0] q5_10_t;
    typedef logic [SQ_W-1:0]       sq_t;

    // lane 0 in the low bits
    typedef q5_10_t [LANES-1:0] ln_vec_t;

    typedef struct packed {
        ln_vec_t diff;
        q5_10_t  mean;
        q5_10_t  variance;
    } ln_stats_t;

    // one lsb of Q5.10
    localparam q5_10_t EPSILON = q5_10_t'(1);

endpackage

`default_nettype wire

//--- pipe_adder_tree.sv
// registered pairwise adder tree over LANES words, one level per cycle
// sum and out_valid trail in_valid by TREE_LAT clocks, no stall
`default_nettype none
`timescale 1ns/1ps

module pipe_adder_tree #(
    parameter int IN_W      = 16,
    parameter bit is_signed = 1'b1
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [ln_pkg::LANES-1:0][IN_W-1:0]  in_lanes,
    output logic                                out_valid,
    output logic [IN_W+ln_pkg::LANE_SHIFT-1:0]  sum
);
    import ln_pkg::*;

    localparam int SUM_W = IN_W + LANE_SHIFT;

    // heap order: node 1 is the root, node i adds nodes 2i and 2i+1
    // nodes LANES/2 .. LANES-1 form the first level
    logic [SUM_W-1:0]    node [1:LANES-1];
    logic [TREE_LAT-1:0] vld_q;

    function automatic logic [SUM_W-1:0] extend(input logic [IN_W-1:0] v);
        if (is_signed) begin
            extend = {{LANE_SHIFT{v[IN_W-1]}}, v};
        end else begin
            extend = {{LANE_SHIFT{1'b0}}, v};
        end
    endfunction

    // valid travels one level per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[TREE_LAT-2:0], in_valid};
        end
    end

    // ====================
    // adder levels
    // ====================
    always_ff @(posedge clk) begin
        // first level straight from the input lanes
        if (in_valid) begin
            for (int k = 0; k < LANES / 2; k++) begin
                node[LANES/2 + k] <= extend(in_lanes[2*k]) + extend(in_lanes[2*k+1]);
            end
        end
        // each further level loads behind the valid of the one below it
        for (int l = 2; l <= LANE_SHIFT; l++) begin
            if (vld_q[l-2]) begin
                for (int k = 0; k < (LANES >> l); k++) begin
                    node[(LANES >> l) + k] <= node[2*((LANES >> l) + k)]
                                            + node[2*((LANES >> l) + k) + 1];
                end
            end
        end
    end

    assign sum       = node[1];
    assign out_valid = vld_q[TREE_LAT-1];

endmodule

`default_nettype wire

//--- ln_mean_unit.sv
// mean of each input vector and the per-lane differences from it
// results and diff_valid come MEAN_LAT clocks after in_valid
`default_nettype none
`timescale 1ns/1ps

module ln_mean_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  ln_pkg::ln_vec_t in_vec,
    output logic            diff_valid,
    output ln_pkg::ln_vec_t diff_vec,
    output ln_pkg::q5_10_t  mean
);
    import ln_pkg::*;

    logic                             sum_valid;
    logic signed [Q_W+LANE_SHIFT-1:0] sum;
    ln_vec_t                          lane_d [TREE_LAT];
    q5_10_t                           mean_c;

    pipe_adder_tree #(
        .IN_W      (Q_W),
        .is_signed (1'b1)
    ) u_sum_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_lanes  (in_vec),
        .out_valid (sum_valid),
        .sum       (sum)
    );

    // input lanes wait here until their sum leaves the tree
    always_ff @(posedge clk) begin
        lane_d[0] <= in_vec;
        for (int i = 1; i < TREE_LAT; i++) begin
            lane_d[i] <= lane_d[i-1];
        end
    end

    // divide by LANES, rounds toward minus infinity
    assign mean_c = q5_10_t'(sum >>> LANE_SHIFT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            diff_valid <= 1'b0;
        end else begin
            diff_valid <= sum_valid;
        end
    end

    // differences wrap at 16 bits
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            mean <= mean_c;
            for (int i = 0; i < LANES; i++) begin
                diff_vec[i] <= lane_d[TREE_LAT-1][i] - mean_c;
            end
        end
    end

endmodule

`default_nettype wire

//--- ln_variance_unit.sv
// variance plus epsilon from the difference vector of the mean unit
// mean and differences are delayed to leave together with the variance
`default_nettype none
`timescale 1ns/1ps

module ln_variance_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              diff_valid,
    input  ln_pkg::ln_vec_t   diff_vec,
    input  ln_pkg::q5_10_t    mean,
    output logic              out_valid,
    output ln_pkg::ln_stats_t out_stats
);
    import ln_pkg::*;

    logic                       sq_valid;
    sq_t [LANES-1:0]            sq_q;
    logic                       sum_valid;
    logic [SQ_W+LANE_SHIFT-1:0] sum;
    ln_vec_t                    diff_d [VAR_LAT];
    q5_10_t                     mean_d [VAR_LAT];
    q5_10_t                     variance;

    // Q10.20 product, back to Q.10 by dropping the low fraction bits
    function automatic sq_t scaled_square(input q5_10_t d);
        logic signed [2*Q_W-1:0] prod;
        prod = d * d;
        return prod[2*Q_W-1:FRAC_BITS];
    endfunction

    // ====================
    // squares
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_valid <= 1'b0;
        end else begin
            sq_valid <= diff_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (diff_valid) begin
            for (int i = 0; i < LANES; i++) begin
                sq_q[i] <= scaled_square(diff_vec[i]);
            end
        end
    end

    pipe_adder_tree #(
        .IN_W      (SQ_W),
        .is_signed (1'b0)
    ) u_sq_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sq_valid),
        .in_lanes  (sq_q),
        .out_valid (sum_valid),
        .sum       (sum)
    );

    // ====================
    // alignment
    // ====================
    // matches square register plus tree
    always_ff @(posedge clk) begin
        diff_d[0] <= diff_vec;
        mean_d[0] <= mean;
        for (int i = 1; i < VAR_LAT; i++) begin
            diff_d[i] <= diff_d[i-1];
            mean_d[i] <= mean_d[i-1];
        end
    end

    // sum / LANES, low 16 bits, then epsilon with wrap-around
    assign variance = sum[Q_W+LANE_SHIFT-1:LANE_SHIFT] + EPSILON;

    assign out_valid          = sum_valid;
    assign out_stats.diff     = diff_d[VAR_LAT-1];
    assign out_stats.mean     = mean_d[VAR_LAT-1];
    assign out_stats.variance = variance;

endmodule

`default_nettype wire

//--- ln_preprocess.sv
// layer-norm pre-processing top, one Q5.10 vector per clock
// out_stats holds differences, mean and variance, MEAN_LAT + VAR_LAT after input
`default_nettype none
`timescale 1ns/1ps

module ln_preprocess (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  ln_pkg::ln_vec_t   in_vec,
    output logic              out_valid,
    output ln_pkg::ln_stats_t out_stats
);
    import ln_pkg::*;

    // mean unit to variance unit
    logic    diff_valid;
    ln_vec_t diff_vec;
    q5_10_t  mean;

    ln_mean_unit u_mean (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_vec     (in_vec),
        .diff_valid (diff_valid),
        .diff_vec   (diff_vec),
        .mean       (mean)
    );

    ln_variance_unit u_variance (
        .clk        (clk),
        .rst_n      (rst_n),
        .diff_valid (diff_valid),
        .diff_vec   (diff_vec),
        .mean       (mean),
        .out_valid  (out_valid),
        .out_stats  (out_stats)
    );

endmodule

`default_nettype wire

//--- tb_ln_preprocess.sv
// directed testbench for the layer-norm pre-processing top
// a reference model queues expected results for the output monitor
// run through the Makefile in this folder
`default_nettype none
`timescale 1ns/1ps

module tb_ln_preprocess;
    import ln_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int DRIVE_DLY      = 1;
    // clocks from in_valid to out_valid
    localparam int PIPE_LAT       = 10;
    localparam int RESULT_TIMEOUT = 200;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    ln_vec_t   in_vec;
    logic      out_valid;
    ln_stats_t out_stats;

    integer    seed;
    int        cycle_cnt = 0;
    ln_stats_t exp_q [$];
    int        cyc_q [$];
    ln_stats_t last_stats;

    ln_preprocess dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_vec    (in_vec),
        .out_valid (out_valid),
        .out_stats (out_stats)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ====================
    // helpers
    // ====================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
        end
    endtask

    // mean rounds toward minus infinity
    // each square keeps bits 31..10
    function automatic ln_stats_t model(input ln_vec_t v);
        ln_stats_t          r;
        int                 total;
        int                 mean_i;
        q5_10_t             d;
        logic signed [31:0] d_ext;
        logic signed [31:0] p;
        logic [31:0]        acc;
        total = 0;
        for (int i = 0; i < LANES; i++) begin
            total += int'(v[i]);
        end
        mean_i = total >>> 4;
        r.mean = mean_i[15:0];
        acc = '0;
        for (int i = 0; i < LANES; i++) begin
            d         = v[i] - r.mean;
            r.diff[i] = d;
            d_ext     = {{16{d[15]}}, d};
            p         = d_ext * d_ext;
            acc       = acc + {10'd0, p[31:10]};
        end
        r.variance = acc[19:4] + 16'd1;
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic send_vec(input ln_vec_t v);
        in_valid = 1'b1;
        in_vec   = v;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic random_vec(output ln_vec_t v);
        integer r;
        for (int i = 0; i < LANES; i++) begin
            r    = $random(seed);
            v[i] = r[15:0];
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= RESULT_TIMEOUT) begin
                stop_with_failure("timeout while waiting for outstanding results");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    // ====================
    // output monitor
    // ====================
    // checks each result on the falling edge
    always @(negedge clk) begin
        ln_stats_t exp_s;
        int        lat;
        if (rst_n) begin
            if (in_valid === 1'b1) begin
                exp_q.push_back(model(in_vec));
                cyc_q.push_back(cycle_cnt);
            end
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("out_valid went high with no vector in flight");
                end else begin
                    exp_s = exp_q.pop_front();
                    lat   = cycle_cnt - cyc_q.pop_front();
                    check("latency", 16'(lat), 16'(PIPE_LAT));
                    check("mean", out_stats.mean, exp_s.mean);
                    check("variance", out_stats.variance, exp_s.variance);
                    for (int i = 0; i < LANES; i++) begin
                        check($sformatf("diff[%0d]", i), out_stats.diff[i], exp_s.diff[i]);
                    end
                    last_stats = out_stats;
                end
            end else if (out_valid !== 1'b0) begin
                stop_with_failure("out_valid is unknown after reset");
            end
        end
    end

    // ====================
    // tests
    // ====================
    task automatic reset_state();
        for (int i = 0; i < 2; i++) begin
            next_cycle();
            check("out_valid", 16'(out_valid), 16'h0000);
        end
        rst_n = 1'b1;
        // no vector in flight yet
        // the monitor flags any pulse here
        idle(PIPE_LAT + 2);
    endtask

    task automatic constant_vector();
        ln_vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = 16'h0C00;
        end
        send_vec(v);
        wait_results();
        check("mean", last_stats.mean, 16'h0C00);
        check("variance", last_stats.variance, 16'h0001);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("diff[%0d]", i), last_stats.diff[i], 16'h0000);
        end
    endtask

    task automatic alternating_lanes();
        ln_vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = (i % 2 == 0) ? 16'h0400 : 16'hFC00;
        end
        send_vec(v);
        wait_results();
        check("mean", last_stats.mean, 16'h0000);
        check("variance", last_stats.variance, 16'h0401);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("diff[%0d]", i), last_stats.diff[i], v[i]);
        end
    endtask

    // sum of -1 gives a mean of -1 lsb
    task automatic negative_rounding();
        ln_vec_t v;
        v    = '0;
        v[0] = 16'hFFFF;
        send_vec(v);
        wait_results();
        check("mean", last_stats.mean, 16'hFFFF);
        check("diff[0]", last_stats.diff[0], 16'h0000);
        for (int i = 1; i < LANES; i++) begin
            check($sformatf("diff[%0d]", i), last_stats.diff[i], 16'h0001);
        end
    endtask

    task automatic back_to_back();
        ln_vec_t v;
        for (int i = 0; i < 40; i++) begin
            random_vec(v);
            send_vec(v);
        end
        wait_results();
    endtask

    task automatic random_gaps();
        ln_vec_t v;
        int      gap;
        for (int i = 0; i < 30; i++) begin
            random_vec(v);
            send_vec(v);
            gap = {$random(seed)} % 4;
            idle(gap);
        end
        wait_results();
        // a further pulse has no expected result left
        idle(PIPE_LAT + 2);
    endtask

    initial begin
        seed     = 59;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_vec   = '0;
        reset_state();
        constant_vector();
        alternating_lanes();
        negative_rounding();
        back_to_back();
        random_gaps();
        idle(4);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
ln_pkg.sv
pipe_adder_tree.sv
ln_mean_unit.sv
ln_variance_unit.sv
ln_preprocess.sv
tb_ln_preprocess.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_ln_preprocess
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
